//--- build.f
bus_pkg.sv
master_out_port.sv
master_in_port.sv
master_port.sv
bus_arbiter.sv
slave_port.sv
serial_bus_top.sv
tb_serial_bus.sv

//--- run_sim.sh
#!/bin/sh
# build and run the serial bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_serial_bus \
	-o sim_serial_bus && ./obj_dir/sim_serial_bus | tee sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "simulation ok" || {
	echo "simulation failed"
	exit 1
}

//--- tb_serial_bus.sv
////////////////////
// serial bus testbench
// drives commands into both masters, keeps
// a model of both slave memories and checks
// every finished transfer against it
////////////////////
`timescale 1ns/1ps

module tb_serial_bus import bus_pkg::*; ();

	localparam int WAIT_LIMIT = 400;
	localparam instr_t INSTR_IDLE = 2'b00;

	logic clk;
	logic rst;
	master_cmd_t cmd [N_MASTERS];
	master_rsp_t rsp [N_MASTERS];

	// command each master is working on
	logic pend_read [N_MASTERS];
	logic [SLAVE_LEN-1:0] pend_sel [N_MASTERS];
	logic [ADDR_LEN-1:0] pend_addr [N_MASTERS];
	logic [DATA_LEN-1:0] pend_data [N_MASTERS];
	int issue_count [N_MASTERS];
	int done_count [N_MASTERS];

	// slave memory model where unwritten bytes read as zero
	logic [DATA_LEN-1:0] model_s0 [int];
	logic [DATA_LEN-1:0] model_s1 [int];

	integer seed;
	int first_done;
	logic [31:0] rnd;

	serial_bus_top i_serial_bus_top (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.rsp(rsp)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	function automatic logic [DATA_LEN-1:0] expected_read(
		input logic [SLAVE_LEN-1:0] sel,
		input logic [ADDR_LEN-1:0] addr
	);
		logic [DATA_LEN-1:0] value;
		value = '0;
		if (sel == 1'b0) begin
			if (model_s0.exists(int'(addr))) begin
				value = model_s0[int'(addr)];
			end
		end else begin
			if (model_s1.exists(int'(addr))) begin
				value = model_s1[int'(addr)];
			end
		end
		return value;
	endfunction

	task automatic store_write(
		input logic [SLAVE_LEN-1:0] sel,
		input logic [ADDR_LEN-1:0] addr,
		input logic [DATA_LEN-1:0] data
	);
		if (sel == 1'b0) begin
			model_s0[int'(addr)] = data;
		end else begin
			model_s1[int'(addr)] = data;
		end
	endtask

	task automatic stop_on_error();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(
		input string name,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_error();
		end
	endtask

	// put a command on one master and hold it until its trans_done
	task automatic start_cmd(
		input int m,
		input instr_t instr,
		input logic [SLAVE_LEN-1:0] sel,
		input logic [ADDR_LEN-1:0] addr,
		input logic [DATA_LEN-1:0] data
	);
		pend_read[m] = (instr == INSTR_READ);
		pend_sel[m] = sel;
		pend_addr[m] = addr;
		pend_data[m] = data;
		issue_count[m] = issue_count[m] + 1;
		cmd[m] = '{instruction: instr, slave_select: sel, address: addr, data: data};
	endtask

	task automatic wait_done(input int m);
		int cycles;
		cycles = 0;
		while (!rsp[m].trans_done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!rsp[m].trans_done) begin
			$display("timeout: master %0d did not finish its transfer in %0d cycles",
				m, WAIT_LIMIT);
			stop_on_error();
		end
		// idle for a cycle so the master rearms
		cmd[m].instruction = INSTR_IDLE;
		@(negedge clk);
	endtask

	task automatic run_cmd(
		input int m,
		input instr_t instr,
		input logic [SLAVE_LEN-1:0] sel,
		input logic [ADDR_LEN-1:0] addr,
		input logic [DATA_LEN-1:0] data
	);
		start_cmd(m, instr, sel, addr, data);
		wait_done(m);
	endtask

	// wait for both busy masters and note who ends first
	task automatic wait_both();
		int cycles;
		logic [N_MASTERS-1:0] done;
		cycles = 0;
		done = '0;
		first_done = -1;
		while (done != '1 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			for (int m = 0; m < N_MASTERS; m++) begin
				if (rsp[m].trans_done && !done[m]) begin
					done[m] = 1'b1;
					cmd[m].instruction = INSTR_IDLE;
					if (first_done < 0) begin
						first_done = m;
					end
				end
			end
		end
		if (done != '1) begin
			$display("timeout: the two masters did not both finish in %0d cycles", WAIT_LIMIT);
			stop_on_error();
		end
		@(negedge clk);
	endtask

	// every finished transfer against the model
	always @(negedge clk) begin
		if (!rst) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				if (rsp[m].trans_done) begin
					if (done_count[m] >= issue_count[m]) begin
						$display("master %0d raised trans_done without a command", m);
						stop_on_error();
					end
					done_count[m] = done_count[m] + 1;
					check_value("rsp.rx_done", 32'(rsp[m].rx_done), 32'(pend_read[m]));
					check_value("rsp.tx_done", 32'(rsp[m].tx_done), 32'(!pend_read[m]));
					if (pend_read[m]) begin
						check_value("rsp.data_in", 32'(rsp[m].data_in),
							32'(expected_read(pend_sel[m], pend_addr[m])));
					end else begin
						store_write(pend_sel[m], pend_addr[m], pend_data[m]);
					end
				end
			end
		end
	end

	initial begin
		seed = 32'h94263a1f;
		clk = 1'b0;
		rst = 1'b1;
		for (int m = 0; m < N_MASTERS; m++) begin
			cmd[m] = '0;
			issue_count[m] = 0;
			done_count[m] = 0;
		end
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// quiet bus with idle commands
		repeat (20) begin
			@(negedge clk);
			for (int m = 0; m < N_MASTERS; m++) begin
				check_value("rsp.tx_done", 32'(rsp[m].tx_done), 32'h0);
				check_value("rsp.rx_done", 32'(rsp[m].rx_done), 32'h0);
				check_value("rsp.trans_done", 32'(rsp[m].trans_done), 32'h0);
			end
		end

		// write then read back on master 0 and slave 0
		run_cmd(0, INSTR_WRITE, 1'b0, 12'h0a5, 8'h3c);
		run_cmd(0, INSTR_READ, 1'b0, 12'h0a5, 8'h00);
		check_value("rsp[0].data_in", 32'(rsp[0].data_in), 32'h3c);

		// same address in both slaves written by different masters
		run_cmd(0, INSTR_WRITE, 1'b0, 12'h7e1, 8'h5a);
		run_cmd(1, INSTR_WRITE, 1'b1, 12'h7e1, 8'hc3);
		run_cmd(1, INSTR_READ, 1'b0, 12'h7e1, 8'h00);
		check_value("rsp[1].data_in", 32'(rsp[1].data_in), 32'h5a);
		run_cmd(0, INSTR_READ, 1'b1, 12'h7e1, 8'h00);
		check_value("rsp[0].data_in", 32'(rsp[0].data_in), 32'hc3);
		// never written
		run_cmd(1, INSTR_READ, 1'b1, 12'hfff, 8'h00);
		check_value("rsp[1].data_in", 32'(rsp[1].data_in), 32'h00);

		// under contention master 0 writes before master 1 reads it
		start_cmd(0, INSTR_WRITE, 1'b1, 12'h3c4, 8'h96);
		start_cmd(1, INSTR_READ, 1'b1, 12'h3c4, 8'h00);
		wait_both();
		check_value("first trans_done master", 32'(first_done), 32'h0);
		check_value("rsp[1].data_in", 32'(rsp[1].data_in), 32'h96);
		start_cmd(0, INSTR_READ, 1'b0, 12'h7e1, 8'h00);
		start_cmd(1, INSTR_READ, 1'b1, 12'h7e1, 8'h00);
		wait_both();
		check_value("first trans_done master", 32'(first_done), 32'h0);
		check_value("rsp[0].data_in", 32'(rsp[0].data_in), 32'h5a);
		check_value("rsp[1].data_in", 32'(rsp[1].data_in), 32'hc3);

		// random traffic mostly in a small window so reads hit writes
		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			run_cmd(int'(rnd[0]), rnd[2] ? INSTR_READ : INSTR_WRITE, rnd[1],
				rnd[3] ? rnd[15:4] : {8'h12, rnd[7:4]}, rnd[31:24]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- serial_bus_top.sv
////////////////////
// serial bus top
// two masters and two memory slaves on
// one set of arbitrated serial lines
////////////////////
`timescale 1ns/1ps

module serial_bus_top import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input master_cmd_t cmd [N_MASTERS],
	output master_rsp_t rsp [N_MASTERS]
);

	bus_lines_t master_lines [N_MASTERS];
	bus_lines_t bus;
	logic [N_MASTERS-1:0] approval_request;
	logic [N_MASTERS-1:0] approval_grant;
	logic [N_MASTERS-1:0] trans_done;
	logic bus_busy;
	logic [1:0] s_ready;
	logic [1:0] s_valid;
	logic [1:0] s_rx_data;
	logic slave_ready;
	logic slave_valid;
	logic rx_data;

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
		master_port i_master_port (
			.clk(clk),
			.rst(rst),
			.cmd(cmd[m]),
			.rsp(rsp[m]),
			.approval_grant(approval_grant[m]),
			.bus_busy(bus_busy),
			.slave_valid(slave_valid),
			.slave_ready(slave_ready),
			.rx_data(rx_data),
			.approval_request(approval_request[m]),
			.lines(master_lines[m])
		);
		assign trans_done[m] = rsp[m].trans_done;
	end

	bus_arbiter i_bus_arbiter (
		.clk(clk),
		.rst(rst),
		.approval_request(approval_request),
		.trans_done(trans_done),
		.master_lines(master_lines),
		.approval_grant(approval_grant),
		.bus_busy(bus_busy),
		.bus(bus)
	);

	slave_port #(.SLAVE_ID(1'b0)) i_slave_port_0 (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.slave_ready(s_ready[0]),
		.slave_valid(s_valid[0]),
		.rx_data(s_rx_data[0])
	);

	slave_port #(.SLAVE_ID(1'b1)) i_slave_port_1 (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.slave_ready(s_ready[1]),
		.slave_valid(s_valid[1]),
		.rx_data(s_rx_data[1])
	);

	// idle slave drives zeros, so or is enough
	assign slave_ready = |s_ready;
	assign slave_valid = |s_valid;
	assign rx_data = |s_rx_data;

endmodule

//--- slave_port.sv
////////////////////
// slave port
// decodes select and address from the bus,
// writes or reads its byte memory and
// shifts read data back on rx_data
////////////////////
`timescale 1ns/1ps

module slave_port import bus_pkg::*; #(
	parameter logic [SLAVE_LEN-1:0] SLAVE_ID = '0
) (
	input logic clk,
	input logic rst,
	input bus_lines_t bus,
	output logic slave_ready,
	output logic slave_valid,
	output logic rx_data
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_STALL,
		S_DATA,
		S_WRITE,
		S_RD_MEM,
		S_RD_SHIFT,
		S_END
	} state_t;

	state_t state;
	logic [SLAVE_LEN-1:0] sel_sr;
	logic [SLAVE_LEN:0] sel_cat;
	logic [ADDR_LEN-1:0] addr_sr;
	logic [DATA_LEN-1:0] data_sr;
	logic [CNT_LEN-1:0] bit_cnt;
	logic [DATA_LEN-1:0] mem [2**ADDR_LEN];

	// memory starts cleared
	initial begin
		for (int i = 0; i < 2**ADDR_LEN; i++) begin
			mem[i] = '0;
		end
	end

	// incoming select bit joined with the bits so far
	assign sel_cat = {bus.tx_slave_select, sel_sr};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				// select phase is taken straight from idle
				S_IDLE: begin
					if (bus.master_valid) begin
						if (bit_cnt == CNT_LEN'(SLAVE_LEN - 1)) begin
							bit_cnt <= '0;
							if (sel_cat[SLAVE_LEN:1] == SLAVE_ID) begin
								state <= S_ADDR;
							end else begin
								// someone else's transfer
								state <= S_END;
							end
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				S_ADDR: begin
					if (bit_cnt == CNT_LEN'(ADDR_LEN - 1)) begin
						bit_cnt <= '0;
						state <= S_STALL;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				// one not-ready cycle, master shows write or read
				S_STALL: begin
					if (bus.write_en) begin
						state <= S_DATA;
					end else if (bus.read_en) begin
						state <= S_RD_MEM;
					end else begin
						state <= S_END;
					end
				end
				S_DATA: begin
					if (bit_cnt == CNT_LEN'(DATA_LEN - 1)) begin
						bit_cnt <= '0;
						state <= S_WRITE;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				S_WRITE: state <= S_END;
				S_RD_MEM: state <= S_RD_SHIFT;
				S_RD_SHIFT: begin
					if (bus.master_ready) begin
						if (bit_cnt == CNT_LEN'(DATA_LEN - 1)) begin
							bit_cnt <= '0;
							state <= S_END;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				// wait out the frame so it is not decoded again
				S_END: begin
					if (!bus.master_valid) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// shift registers and memory port
	always_ff @(posedge clk) begin
		if (state == S_IDLE && bus.master_valid) begin
			sel_sr <= sel_cat[SLAVE_LEN:1];
		end
		if (state == S_ADDR) begin
			addr_sr <= {bus.tx_address, addr_sr[ADDR_LEN-1:1]};
		end
		if (state == S_DATA) begin
			data_sr <= {bus.tx_data, data_sr[DATA_LEN-1:1]};
		end
		if (state == S_WRITE) begin
			mem[addr_sr] <= data_sr;
		end
		if (state == S_RD_MEM) begin
			data_sr <= mem[addr_sr];
		end else if (state == S_RD_SHIFT && bus.master_ready) begin
			data_sr <= data_sr >> 1;
		end
	end

	// unaddressed slave sits in S_END and drives zeros
	assign slave_ready = (state == S_IDLE) || (state == S_ADDR) || (state == S_DATA);
	assign slave_valid = (state == S_RD_SHIFT);
	assign rx_data = (state == S_RD_SHIFT) && data_sr[0];

	// master keeps ready up for the whole read return
	a_read_ready: assert property (@(posedge clk) disable iff (rst)
		(state == S_RD_SHIFT) |-> bus.master_ready);

endmodule

//--- bus_arbiter.sv
////////////////////
// bus arbiter
// fixed priority grant of the shared lines,
// held until the owner signals trans_done
////////////////////
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [N_MASTERS-1:0] approval_request,
	input logic [N_MASTERS-1:0] trans_done,
	input bus_lines_t master_lines [N_MASTERS],
	output logic [N_MASTERS-1:0] approval_grant,
	output logic bus_busy,
	output bus_lines_t bus
);

	logic [N_MASTERS-1:0] pick;

	// walk down from the top so the lowest index wins
	always_comb begin
		pick = '0;
		for (int i = N_MASTERS - 1; i >= 0; i--) begin
			if (approval_request[i]) begin
				pick = '0;
				pick[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			approval_grant <= '0;
			bus_busy <= 1'b0;
		end else if (bus_busy) begin
			// only the owner can end the tenure
			if (|(approval_grant & trans_done)) begin
				approval_grant <= '0;
				bus_busy <= 1'b0;
			end
		end else if (|pick) begin
			approval_grant <= pick;
			bus_busy <= 1'b1;
		end
	end

	// owner's lines onto the bus or zeros when idle
	always_comb begin
		bus = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (approval_grant[i]) begin
				bus = master_lines[i];
			end
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(approval_grant));

endmodule

//--- master_port.sv
////////////////////
// master port
// joins the out and in ports into one
// master and builds trans_done from them
////////////////////
`timescale 1ns/1ps

module master_port import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input master_cmd_t cmd,
	output master_rsp_t rsp,
	input logic approval_grant,
	input logic bus_busy,
	input logic slave_valid,
	input logic slave_ready,
	input logic rx_data,
	output logic approval_request,
	output bus_lines_t lines
);

	bus_lines_t out_lines;
	logic in_master_ready;
	logic [DATA_LEN-1:0] data_in;
	logic rx_done;
	logic tx_done;
	logic read_active;

	// read window opens on read_en, closes on rx_done
	always_ff @(posedge clk) begin
		if (rst) begin
			read_active <= 1'b0;
		end else if (rx_done) begin
			read_active <= 1'b0;
		end else if (out_lines.read_en) begin
			read_active <= 1'b1;
		end
	end

	always_comb begin
		lines = out_lines;
		// both halves must be ready
		lines.master_ready = out_lines.master_ready && in_master_ready;
	end

	// a read's tx_done is only the end of its address
	assign rsp = '{
		data_in: data_in,
		rx_done: rx_done,
		tx_done: tx_done,
		trans_done: rx_done || (tx_done && !out_lines.read_en)
	};

	master_out_port i_master_out_port (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.approval_grant(approval_grant),
		.bus_busy(bus_busy),
		.slave_ready(slave_ready),
		.rx_done(rx_done),
		.approval_request(approval_request),
		.out_lines(out_lines),
		.tx_done(tx_done)
	);

	master_in_port i_master_in_port (
		.clk(clk),
		.rst(rst),
		.read_active(read_active),
		.rx_data(rx_data),
		.slave_valid(slave_valid),
		.master_ready(in_master_ready),
		.data_in(data_in),
		.rx_done(rx_done)
	);

endmodule

//--- master_in_port.sv
////////////////////
// master in port
// collects the read byte from rx_data
// and flags rx_done after the last bit
////////////////////
`timescale 1ns/1ps

module master_in_port import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic read_active,
	input logic rx_data,
	input logic slave_valid,
	output logic master_ready,
	output logic [DATA_LEN-1:0] data_in,
	output logic rx_done
);

	logic [DATA_LEN-1:0] shift_sr;
	logic [CNT_LEN-1:0] bit_cnt;
	logic take;
	logic last;

	// ready for the whole read window
	assign master_ready = read_active;
	assign take = read_active && slave_valid;
	assign last = (bit_cnt == CNT_LEN'(DATA_LEN - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= take && last;
			if (!read_active) begin
				bit_cnt <= '0;
			end else if (take) begin
				if (last) begin
					bit_cnt <= '0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (take) begin
			shift_sr <= {rx_data, shift_sr[DATA_LEN-1:1]};
		end
		// held until the next read completes
		if (take && last) begin
			data_in <= {rx_data, shift_sr[DATA_LEN-1:1]};
		end
	end

endmodule

//--- master_out_port.sv
////////////////////
// master out port
// latches a command, requests the bus and
// shifts slave number, address and write data
// onto the serial lines once granted
////////////////////
`timescale 1ns/1ps

module master_out_port import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input master_cmd_t cmd,
	input logic approval_grant,
	input logic bus_busy,
	input logic slave_ready,
	input logic rx_done,
	output logic approval_request,
	output bus_lines_t out_lines,
	output logic tx_done
);

	typedef enum logic [2:0] {M_IDLE, M_REQ, M_SEL, M_ADDR, M_DATA, M_RWAIT} state_t;

	state_t state;
	master_cmd_t cmd_q;
	logic armed;
	logic cmd_op;
	logic cmd_go;
	logic won;
	logic [SLAVE_LEN-1:0] sel_sr;
	logic [ADDR_LEN-1:0] addr_sr;
	logic [DATA_LEN-1:0] data_sr;
	logic [CNT_LEN-1:0] bit_cnt;

	assign cmd_op = (cmd.instruction == INSTR_WRITE) || (cmd.instruction == INSTR_READ);
	// armed again only once the instruction has gone idle
	assign cmd_go = armed && cmd_op;
	// grant only counts while the arbiter marks the bus owned
	assign won = approval_grant && bus_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= M_IDLE;
			armed <= 1'b1;
			approval_request <= 1'b0;
			tx_done <= 1'b0;
			bit_cnt <= '0;
		end else begin
			tx_done <= 1'b0;
			if (!cmd_op) begin
				armed <= 1'b1;
			end
			case (state)
				M_IDLE: begin
					if (cmd_go) begin
						armed <= 1'b0;
						approval_request <= 1'b1;
						state <= M_REQ;
					end
				end
				M_REQ: begin
					if (won) begin
						bit_cnt <= '0;
						state <= M_SEL;
					end
				end
				// each phase moves one bit per ready cycle
				M_SEL: begin
					if (slave_ready) begin
						if (bit_cnt == CNT_LEN'(SLAVE_LEN - 1)) begin
							bit_cnt <= '0;
							state <= M_ADDR;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				M_ADDR: begin
					if (slave_ready) begin
						if (bit_cnt == CNT_LEN'(ADDR_LEN - 1)) begin
							bit_cnt <= '0;
							if (cmd_q.instruction == INSTR_WRITE) begin
								state <= M_DATA;
							end else begin
								// read sends nothing after the address
								tx_done <= 1'b1;
								state <= M_RWAIT;
							end
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				M_DATA: begin
					if (slave_ready) begin
						if (bit_cnt == CNT_LEN'(DATA_LEN - 1)) begin
							bit_cnt <= '0;
							tx_done <= 1'b1;
							approval_request <= 1'b0;
							state <= M_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				// bus stays ours until the read byte is in
				M_RWAIT: begin
					if (rx_done) begin
						approval_request <= 1'b0;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// command and shift registers
	always_ff @(posedge clk) begin
		if (state == M_IDLE && cmd_go) begin
			cmd_q <= cmd;
		end
		if (state == M_REQ && won) begin
			sel_sr <= cmd_q.slave_select;
			addr_sr <= cmd_q.address;
			data_sr <= cmd_q.data;
		end else if (slave_ready) begin
			// lsb first, hold while stalled
			if (state == M_SEL) begin
				sel_sr <= sel_sr >> 1;
			end
			if (state == M_ADDR) begin
				addr_sr <= addr_sr >> 1;
			end
			if (state == M_DATA) begin
				data_sr <= data_sr >> 1;
			end
		end
	end

	always_comb begin
		out_lines = '0;
		// valid frames the whole transfer
		out_lines.master_valid = (state == M_SEL) || (state == M_ADDR) ||
			(state == M_DATA) || (state == M_RWAIT);
		out_lines.tx_slave_select = (state == M_SEL) && sel_sr[0];
		out_lines.tx_address = (state == M_ADDR) && addr_sr[0];
		out_lines.tx_data = (state == M_DATA) && data_sr[0];
		out_lines.write_en = (state == M_DATA);
		out_lines.read_en = (state == M_RWAIT);
		out_lines.master_ready = (state == M_RWAIT);
	end

	// arbiter must have granted before any frame starts
	a_valid_needs_grant: assert property (@(posedge clk) disable iff (rst)
		$rose(out_lines.master_valid) |-> approval_grant);

endmodule

//--- bus_pkg.sv
////////////////////
// serial bus package
// widths, instruction codes and the
// command, response and bus line structs
// shared by masters, arbiter and slaves
////////////////////
package bus_pkg;

	// slave number, address and data widths
	localparam int SLAVE_LEN = 1;
	localparam int ADDR_LEN = 12;
	localparam int DATA_LEN = 8;
	localparam int N_MASTERS = 2;

	// bit counter wide enough for the longest serial phase
	localparam int CNT_LEN = $clog2(ADDR_LEN + 1);

	typedef logic [1:0] instr_t;

	// other codes mean idle
	localparam instr_t INSTR_WRITE = 2'b10;
	localparam instr_t INSTR_READ = 2'b11;

	// command handed to a master port, 23 bits
	typedef struct packed {
		instr_t instruction;
		logic [SLAVE_LEN-1:0] slave_select;
		logic [ADDR_LEN-1:0] address;
		logic [DATA_LEN-1:0] data;
	} master_cmd_t;

	// status back to the command source, 11 bits
	typedef struct packed {
		logic [DATA_LEN-1:0] data_in;
		logic rx_done;
		logic tx_done;
		logic trans_done;
	} master_rsp_t;

	// one master's outgoing serial lines, 7 bits
	typedef struct packed {
		logic tx_slave_select;
		logic tx_address;
		logic tx_data;
		logic master_valid;
		logic master_ready;
		logic write_en;
		logic read_en;
	} bus_lines_t;

endpackage
